// ==== link_pkg.sv ====
// Shared definitions for the serial link lane model.
// Imported by every block of the link, and by the testbench.

package link_pkg;

	// ------------------------------------------------------------------
	// Lane word, 8B/10B bypassed
	// ------------------------------------------------------------------
	// One 10-bit word with two decodings
	// Bit 9 is disparity mode on transmit and disparity error on receive
	// Bit 8 is disparity value on transmit and char-is-K on receive
	typedef union packed {
		struct packed {
			logic       char_disp_mode;
			logic       char_disp_val;
			logic [7:0] data;
		} tx;
		struct packed {
			logic       disperr;
			logic       charisk;
			logic [7:0] data;
		} rx;
	} lane_word_u;

	// K28.5 marks alignment, K28.0 fills empty slots
	localparam logic [7:0] COMMA_CODE = 8'hBC;
	localparam logic [7:0] IDLE_CODE  = 8'h1C;

	// ------------------------------------------------------------------
	// Timing
	// ------------------------------------------------------------------
	localparam int COMMA_PERIOD      = 16;
	localparam int LANE_LATENCY      = 4;
	localparam int PLL_LOCK_CYCLES   = 16;
	localparam int RESET_DONE_CYCLES = 8;

	// Word slot counter between commas
	localparam int PERIOD_W = $clog2(COMMA_PERIOD);
	localparam logic [PERIOD_W-1:0] LAST_SLOT = PERIOD_W'(COMMA_PERIOD - 1);

	// Lane power-up sequencer spans lock and reset done
	localparam int SEQ_CNT_W = $clog2(PLL_LOCK_CYCLES + RESET_DONE_CYCLES);

	// ------------------------------------------------------------------
	// Elastic buffer
	// ------------------------------------------------------------------
	localparam int BUF_DEPTH = 8;
	localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
	localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

	// Encodings follow the transceiver RXBUFSTATUS style
	typedef enum logic [2:0] {
		BUF_NOMINAL  = 3'b000,
		BUF_HALF     = 3'b010,
		BUF_OVERFLOW = 3'b110
	} buf_status_t;

	localparam int DISPERR_CNT_W = 16;

endpackage

// ==== link_tx_framer.sv ====
// Transmit framer: payload bytes in, raw 10-bit lane words out.
// Commas are placed at a fixed spacing, idles fill slots with no payload.

`timescale 1ns/1ps

module link_tx_framer import link_pkg::*; (
	input  logic       tx_clk,
	input  logic       rst_i,
	input  logic [7:0] pay_data_i,
	input  logic       pay_valid_i,
	output logic       pay_ready_o,
	input  logic       resetdone_i,
	output lane_word_u tx_word_o
);

	// Slot position within the comma period, slot 0 carries the comma
	logic [PERIOD_W-1:0] slot_q;
	logic                comma_slot;
	logic                comma_out;

	// Counter only runs while the lane takes words
	always_ff @(posedge tx_clk) begin
		if (rst_i) begin
			slot_q <= '0;
		end else if (resetdone_i) begin
			if (slot_q == LAST_SLOT) begin
				slot_q <= '0;
			end else begin
				slot_q <= slot_q + 1'b1;
			end
		end
	end

	assign comma_slot = (slot_q == '0);

	// Payload is only taken in non-comma slots of a running lane
	assign pay_ready_o = resetdone_i && !comma_slot;

	// ------------------------------------------------------------------
	// Word mux
	// ------------------------------------------------------------------
	always_comb begin
		// Disparity mode unused with the encoder bypassed
		tx_word_o.tx.char_disp_mode = 1'b0;
		if (resetdone_i && comma_slot) begin
			tx_word_o.tx.char_disp_val = 1'b1;
			tx_word_o.tx.data          = COMMA_CODE;
		end else if (resetdone_i && pay_valid_i) begin
			// Accepted byte goes out as a plain data char
			tx_word_o.tx.char_disp_val = 1'b0;
			tx_word_o.tx.data          = pay_data_i;
		end else begin
			// Nothing waiting, or lane not up yet
			tx_word_o.tx.char_disp_val = 1'b1;
			tx_word_o.tx.data          = IDLE_CODE;
		end
	end

	assign comma_out = tx_word_o.tx.char_disp_val && (tx_word_o.tx.data == COMMA_CODE);

	// A payload handshake puts that very byte on the wire as data
	// so it can never fall into a comma slot
	a_no_ready_in_comma: assert property (@(posedge tx_clk) disable iff (rst_i)
		(pay_valid_i && pay_ready_o) |->
			!tx_word_o.tx.char_disp_val && (tx_word_o.tx.data == pay_data_i))
		else $error("framer offered ready in a comma slot");

	// Comma spacing on the wire is exactly one period
	a_comma_spacing: assert property (@(posedge tx_clk) disable iff (rst_i)
		(resetdone_i && comma_out) |-> ##COMMA_PERIOD comma_out)
		else $error("framer comma spacing broken");

endmodule

// ==== lane_loopback.sv ====
// Behavioral stand-in for one transceiver lane looped back onto itself.
// Sequences PLL lock and reset done, then delays words by a fixed latency.
// Test hooks inject disparity errors and slip single words.

`timescale 1ns/1ps

module lane_loopback import link_pkg::*; (
	input  logic       tx_clk,
	input  logic       rst_i,
	input  lane_word_u tx_word_i,
	input  logic       disperr_inject_i,
	input  logic       slip_i,
	output logic       plllkdet_o,
	output logic       resetdone_o,
	output lane_word_u rx_word_o,
	output logic       rx_word_valid_o
);

	// ------------------------------------------------------------------
	// Power-up sequencer
	// ------------------------------------------------------------------
	logic [SEQ_CNT_W-1:0] seq_q;
	logic                 plllkdet_q;
	logic                 resetdone_q;

	// One counter covers both phases, it freezes once reset is done
	always_ff @(posedge tx_clk) begin
		if (rst_i) begin
			seq_q       <= '0;
			plllkdet_q  <= 1'b0;
			resetdone_q <= 1'b0;
		end else if (!resetdone_q) begin
			seq_q <= seq_q + 1'b1;
			if (seq_q == SEQ_CNT_W'(PLL_LOCK_CYCLES - 1)) begin
				plllkdet_q <= 1'b1;
			end
			if (seq_q == SEQ_CNT_W'(PLL_LOCK_CYCLES + RESET_DONE_CYCLES - 1)) begin
				resetdone_q <= 1'b1;
			end
		end
	end

	assign plllkdet_o  = plllkdet_q;
	assign resetdone_o = resetdone_q;

	// ------------------------------------------------------------------
	// Delay line
	// ------------------------------------------------------------------
	lane_word_u              lane_in;
	lane_word_u              line_q [LANE_LATENCY];
	logic [LANE_LATENCY-1:0] line_vld_q;

	// Tx bits map straight onto rx bits
	// Injection forces the error flag on the word entering now
	always_comb begin
		lane_in            = tx_word_i;
		lane_in.rx.disperr = tx_word_i.tx.char_disp_mode | disperr_inject_i;
	end

	always_ff @(posedge tx_clk) begin
		line_q[0] <= lane_in;
		for (int i = 1; i < LANE_LATENCY; i++) begin
			line_q[i] <= line_q[i-1];
		end
	end

	// Words enter only after reset done, a slipped word never comes out
	always_ff @(posedge tx_clk) begin
		if (rst_i) begin
			line_vld_q <= '0;
		end else begin
			line_vld_q <= {line_vld_q[LANE_LATENCY-2:0], resetdone_q && !slip_i};
		end
	end

	assign rx_word_o       = line_q[LANE_LATENCY-1];
	assign rx_word_valid_o = line_vld_q[LANE_LATENCY-1];

	// Reset done follows lock, and lock holds once reached
	a_done_after_lock: assert property (@(posedge tx_clk) disable iff (rst_i)
		$rose(resetdone_o) |-> plllkdet_o && $past(plllkdet_o))
		else $error("lane reset done without PLL lock");

endmodule

// ==== rx_elastic_buffer.sv ====
// Elastic buffer between the lane and the deframer.
// The lane cannot be stalled, so writes into a full FIFO are lost
// and flagged as a sticky overflow in the buffer status.

`timescale 1ns/1ps

module rx_elastic_buffer import link_pkg::*; (
	input  logic        tx_clk,
	input  logic        rst_i,
	input  lane_word_u  wr_word_i,
	input  logic        wr_valid_i,
	output lane_word_u  rd_word_o,
	output logic        rd_valid_o,
	input  logic        rd_ready_i,
	output buf_status_t bufstatus_o
);

	lane_word_u           mem_q [BUF_DEPTH];
	logic [BUF_PTR_W-1:0] wr_ptr_q;
	logic [BUF_PTR_W-1:0] rd_ptr_q;
	logic [BUF_CNT_W-1:0] fill_q;
	logic                 ovf_q;
	logic                 full;
	logic                 wr_en;
	logic                 rd_en;

	assign full  = (fill_q == BUF_CNT_W'(BUF_DEPTH));
	assign wr_en = wr_valid_i && !full;
	assign rd_en = rd_valid_o && rd_ready_i;

	// ------------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------------
	always_ff @(posedge tx_clk) begin
		if (wr_en) begin
			mem_q[wr_ptr_q] <= wr_word_i;
		end
	end

	// Depth is a power of two, pointers wrap on their own
	always_ff @(posedge tx_clk) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (rd_en) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	// Fill level, used for empty, full and the half mark
	always_ff @(posedge tx_clk) begin
		if (rst_i) begin
			fill_q <= '0;
		end else begin
			case ({wr_en, rd_en})
				2'b10:   fill_q <= fill_q + 1'b1;
				2'b01:   fill_q <= fill_q - 1'b1;
				default: fill_q <= fill_q;
			endcase
		end
	end

	// Lost word, held until reset
	always_ff @(posedge tx_clk) begin
		if (rst_i) begin
			ovf_q <= 1'b0;
		end else if (wr_valid_i && full) begin
			ovf_q <= 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// Read side and status
	// ------------------------------------------------------------------
	assign rd_word_o  = mem_q[rd_ptr_q];
	assign rd_valid_o = (fill_q != '0);

	always_comb begin
		if (ovf_q) begin
			bufstatus_o = BUF_OVERFLOW;
		end else if (fill_q >= BUF_CNT_W'(BUF_DEPTH / 2)) begin
			bufstatus_o = BUF_HALF;
		end else begin
			bufstatus_o = BUF_NOMINAL;
		end
	end

	a_fill_bound: assert property (@(posedge tx_clk) disable iff (rst_i)
		fill_q <= BUF_CNT_W'(BUF_DEPTH))
		else $error("elastic buffer fill count out of range");

	// Pointers must agree with the fill count whenever a word is popped
	a_no_empty_read: assert property (@(posedge tx_clk) disable iff (rst_i)
		rd_en |-> (wr_ptr_q != rd_ptr_q) || full)
		else $error("elastic buffer read while empty");

endmodule

// ==== rx_deframer.sv ====
// Receive deframer: aligns on commas, drops K characters and passes
// payload bytes on through a valid/ready output register.
// Also counts disparity errors seen on the lane.

`timescale 1ns/1ps

module rx_deframer import link_pkg::*; (
	input  logic                     tx_clk,
	input  logic                     rst_i,
	input  lane_word_u               in_word_i,
	input  logic                     in_valid_i,
	output logic                     in_ready_o,
	output logic [7:0]               out_data_o,
	output logic                     out_valid_o,
	input  logic                     out_ready_i,
	output logic                     byte_aligned_o,
	output logic                     loss_of_sync_o,
	output logic [DISPERR_CNT_W-1:0] disperr_count_o
);

	logic                     aligned_q;
	logic                     los_q;
	logic [PERIOD_W-1:0]      slot_q;
	logic [7:0]               out_data_q;
	logic                     out_valid_q;
	logic [DISPERR_CNT_W-1:0] err_cnt_q;
	logic                     is_comma;
	logic                     slot_end;
	logic                     out_free;
	logic                     take;
	logic                     pass;

	assign is_comma = in_word_i.rx.charisk && (in_word_i.rx.data == COMMA_CODE);
	assign slot_end = (slot_q == LAST_SLOT);
	assign out_free = !out_valid_q || out_ready_i;

	// K words and unaligned data are always swallowed
	// aligned data waits for room in the output register
	assign in_ready_o = in_word_i.rx.charisk || !aligned_q || out_free;
	assign take       = in_valid_i && in_ready_o;

	// Data in the comma slot is a missing comma, not payload
	assign pass = take && !in_word_i.rx.charisk && aligned_q && !slot_end;

	// ------------------------------------------------------------------
	// Comma alignment
	// ------------------------------------------------------------------
	// slot_q counts words since the last comma
	always_ff @(posedge tx_clk) begin
		if (rst_i) begin
			aligned_q <= 1'b0;
			los_q     <= 1'b0;
			slot_q    <= '0;
		end else if (take) begin
			if (is_comma) begin
				slot_q <= '0;
				if (!aligned_q) begin
					aligned_q <= 1'b1;
				end else if (!slot_end) begin
					// Early comma, lock again on the one after
					aligned_q <= 1'b0;
					los_q     <= 1'b1;
				end
			end else begin
				slot_q <= slot_q + 1'b1;
				if (aligned_q && slot_end) begin
					aligned_q <= 1'b0;
					los_q     <= 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------------
	always_ff @(posedge tx_clk) begin
		if (rst_i) begin
			out_valid_q <= 1'b0;
		end else if (pass) begin
			out_valid_q <= 1'b1;
		end else if (out_ready_i) begin
			out_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (pass) begin
			out_data_q <= in_word_i.rx.data;
		end
	end

	// Saturating count, bad words still flow on
	always_ff @(posedge tx_clk) begin
		if (rst_i) begin
			err_cnt_q <= '0;
		end else if (take && in_word_i.rx.disperr && (err_cnt_q != '1)) begin
			err_cnt_q <= err_cnt_q + 1'b1;
		end
	end

	assign out_data_o      = out_data_q;
	assign out_valid_o     = out_valid_q;
	assign byte_aligned_o  = aligned_q;
	assign loss_of_sync_o  = los_q;
	assign disperr_count_o = err_cnt_q;

	a_los_sticky: assert property (@(posedge tx_clk) disable iff (rst_i)
		loss_of_sync_o |=> loss_of_sync_o)
		else $error("loss of sync cleared without reset");

	// A stalled byte holds until the sink takes it
	a_out_hold: assert property (@(posedge tx_clk) disable iff (rst_i)
		(out_valid_o && !out_ready_i) |=> out_valid_o && $stable(out_data_o))
		else $error("deframer output changed under back-pressure");

endmodule

// ==== link_top.sv ====
// Top level of the link lane model: framer, lane, elastic buffer and
// deframer in a loop, with the receive status packed into one word.

`timescale 1ns/1ps

module link_top import link_pkg::*; (
	input  logic                     tx_clk,
	input  logic                     rst_i,
	input  logic [7:0]               pay_data_i,
	input  logic                     pay_valid_i,
	output logic                     pay_ready_o,
	output logic [7:0]               out_data_o,
	output logic                     out_valid_o,
	input  logic                     out_ready_i,
	input  logic                     disperr_inject_i,
	input  logic                     slip_i,
	output logic                     plllkdet_o,
	output logic                     resetdone_o,
	output logic [4:0]               rxstatus_o,
	output logic [DISPERR_CNT_W-1:0] disperr_count_o
);

	// ------------------------------------------------------------------
	// Internal links
	// ------------------------------------------------------------------
	lane_word_u  tx_word;
	lane_word_u  rx_word;
	logic        rx_word_valid;
	lane_word_u  buf_word;
	logic        buf_valid;
	logic        buf_ready;
	buf_status_t bufstatus;
	logic        byte_aligned;
	logic        loss_of_sync;

	link_tx_framer u_framer (
		.tx_clk      (tx_clk),
		.rst_i       (rst_i),
		.pay_data_i  (pay_data_i),
		.pay_valid_i (pay_valid_i),
		.pay_ready_o (pay_ready_o),
		.resetdone_i (resetdone_o),
		.tx_word_o   (tx_word)
	);

	lane_loopback u_lane (
		.tx_clk           (tx_clk),
		.rst_i            (rst_i),
		.tx_word_i        (tx_word),
		.disperr_inject_i (disperr_inject_i),
		.slip_i           (slip_i),
		.plllkdet_o       (plllkdet_o),
		.resetdone_o      (resetdone_o),
		.rx_word_o        (rx_word),
		.rx_word_valid_o  (rx_word_valid)
	);

	rx_elastic_buffer u_buf (
		.tx_clk      (tx_clk),
		.rst_i       (rst_i),
		.wr_word_i   (rx_word),
		.wr_valid_i  (rx_word_valid),
		.rd_word_o   (buf_word),
		.rd_valid_o  (buf_valid),
		.rd_ready_i  (buf_ready),
		.bufstatus_o (bufstatus)
	);

	rx_deframer u_deframer (
		.tx_clk          (tx_clk),
		.rst_i           (rst_i),
		.in_word_i       (buf_word),
		.in_valid_i      (buf_valid),
		.in_ready_o      (buf_ready),
		.out_data_o      (out_data_o),
		.out_valid_o     (out_valid_o),
		.out_ready_i     (out_ready_i),
		.byte_aligned_o  (byte_aligned),
		.loss_of_sync_o  (loss_of_sync),
		.disperr_count_o (disperr_count_o)
	);

	// Status word, top down: loss of sync, aligned, buffer status
	assign rxstatus_o = {loss_of_sync, byte_aligned, bufstatus};

endmodule

// ==== link_tb.sv ====
// Testbench for the link lane model. Random payload runs through framer, lane,
// elastic buffer and deframer and is checked against a byte queue.
// Also covers power-up timing, disparity injection, word slip and overflow.

`timescale 1ns/1ps

module link_tb import link_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int UP_CYCLES    = PLL_LOCK_CYCLES + RESET_DONE_CYCLES;
	localparam int PWR_CYCLES   = RESET_CYCLES + UP_CYCLES + 2;
	localparam int TRAFFIC      = 400;
	localparam int DRAIN        = 120;
	localparam int SYNC_WAIT    = 3 * COMMA_PERIOD + LANE_LATENCY + BUF_DEPTH;
	localparam int OVF_CYCLES   = 4 * BUF_DEPTH;
	// Cycles for in-flight words to clear the lane and a full buffer
	localparam int FLUSH        = LANE_LATENCY + BUF_DEPTH + 2;

	// Sum of all test lengths in cycles
	localparam int TOTAL_CYCLES = 2 * PWR_CYCLES + 2 * (TRAFFIC + DRAIN)
		+ (TRAFFIC + DRAIN + FLUSH) + (TRAFFIC + 2 * SYNC_WAIT + DRAIN + 1)
		+ (OVF_CYCLES + 2 * BUF_DEPTH);

	// How output bytes are matched against the queue
	localparam int MODE_EXACT  = 0;
	localparam int MODE_SUBSEQ = 1;
	localparam int MODE_NONE   = 2;

	logic                     tx_clk;
	logic                     rst_i;
	logic [7:0]               pay_data_i;
	logic                     pay_valid_i;
	logic                     pay_ready_o;
	logic [7:0]               out_data_o;
	logic                     out_valid_o;
	logic                     out_ready_i;
	logic                     disperr_inject_i;
	logic                     slip_i;
	logic                     plllkdet_o;
	logic                     resetdone_o;
	logic [4:0]               rxstatus_o;
	logic [DISPERR_CNT_W-1:0] disperr_count_o;

	// Reference model state
	logic [7:0]               byte_q [$];
	logic                     xfer_q;
	logic [DISPERR_CNT_W-1:0] inj_total;
	int                       mode;
	string                    cur_test;

	link_top dut_i (.*);

	initial begin
		tx_clk = 1'b0;
		forever #(CLK_PERIOD / 2) tx_clk = ~tx_clk;
	end

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD * 2);
		$display("Watchdog expired before the test sequence finished");
		$display("CHECKS FAILED");
		$fatal(1);
	end

	// ------------------------------------------------------------------
	// Failure reporting and compare tasks
	// ------------------------------------------------------------------
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			fail_run($sformatf("ERROR %s: expected 0x%02h, actual 0x%02h", name, exp, act));
		end
	endtask

	task automatic check_status(input string name, input buf_status_t exp,
		input buf_status_t act);
		if (act !== exp) begin
			fail_run($sformatf("ERROR %s: expected %s (%03b), actual %03b",
				name, exp.name(), exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input logic [DISPERR_CNT_W-1:0] exp,
		input logic [DISPERR_CNT_W-1:0] act);
		if (act !== exp) begin
			fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	// ------------------------------------------------------------------
	// Stimulus and model
	// ------------------------------------------------------------------
	task automatic take_output();
		logic [7:0] exp;
		bit         found;
		if (mode == MODE_EXACT) begin
			if (byte_q.size() == 0) begin
				fail_run($sformatf("%s: output byte 0x%02h with no payload outstanding",
					cur_test, out_data_o));
			end else begin
				exp = byte_q.pop_front();
				check_byte(cur_test, exp, out_data_o);
				check_flag({cur_test, " byte_aligned"}, 1'b1, rxstatus_o[3]);
			end
		end else if (mode == MODE_SUBSEQ) begin
			// Skipped entries are bytes lost while out of alignment
			found = 1'b0;
			while (!found && byte_q.size() != 0) begin
				exp   = byte_q.pop_front();
				found = (exp == out_data_o);
			end
			if (!found) begin
				fail_run($sformatf("%s: output byte 0x%02h breaks the payload order",
					cur_test, out_data_o));
			end
		end
	endtask

	// One clock cycle, inputs applied shortly after the rising edge
	task automatic tick(input bit send, input bit ordy, input bit inj, input bit slp);
		@(posedge tx_clk);
		#2;
		// Byte taken on the edge just passed frees the payload slot
		if (xfer_q) begin
			pay_valid_i = 1'b0;
		end
		if (!pay_valid_i && send && ($urandom % 4 != 0)) begin
			pay_valid_i = 1'b1;
			pay_data_i  = 8'($urandom);
		end
		out_ready_i      = ordy;
		disperr_inject_i = inj;
		slip_i           = slp;
		if (inj) begin
			inj_total = inj_total + 1'b1;
		end
		// Handshakes for the coming edge
		xfer_q = pay_valid_i && pay_ready_o;
		if (xfer_q && mode != MODE_NONE) begin
			byte_q.push_back(pay_data_i);
		end
		if (out_valid_o && out_ready_i) begin
			take_output();
		end
		if (mode == MODE_EXACT && buf_status_t'(rxstatus_o[2:0]) == BUF_OVERFLOW) begin
			fail_run({cur_test, ": elastic buffer overflowed during lossless traffic"});
		end
	endtask

	task automatic run_traffic(input int cycles, input int stall_budget, input int inject_odds);
		int burst_left;
		int stall_left;
		int budget;
		bit sending;
		bit inj;
		burst_left = 0;
		stall_left = 0;
		budget     = stall_budget;
		sending    = 1'b0;
		for (int c = 0; c < cycles; c++) begin
			// Payload bursts alternate with quiet gaps
			if (burst_left == 0) begin
				sending    = !sending;
				burst_left = 1 + int'($urandom % 24);
			end
			burst_left--;
			// Rare short sink stall, total capped below the buffer depth
			if (stall_left == 0 && budget > 0 && $urandom % 32 == 0) begin
				stall_left = 1 + int'($urandom % (BUF_DEPTH / 2));
				if (stall_left > budget) begin
					stall_left = budget;
				end
				budget = budget - stall_left;
			end
			inj = 1'b0;
			if (inject_odds > 0 && stall_left == 0) begin
				inj = ($urandom % inject_odds == 0);
			end
			tick(sending, stall_left == 0, inj, 1'b0);
			if (stall_left > 0) begin
				stall_left--;
			end
		end
	endtask

	task automatic drain_exact();
		int n;
		n = 0;
		while ((byte_q.size() != 0 || pay_valid_i) && n < DRAIN) begin
			tick(1'b0, 1'b1, 1'b0, 1'b0);
			n++;
		end
		if (byte_q.size() != 0 || pay_valid_i) begin
			fail_run({cur_test, ": payload bytes still missing after the drain time"});
		end
	endtask

	task automatic wait_status_bit(input logic [2:0] idx, input string what);
		int n;
		n = 0;
		while (!rxstatus_o[idx] && n < SYNC_WAIT) begin
			tick(1'b1, 1'b1, 1'b0, 1'b0);
			n++;
		end
		if (!rxstatus_o[idx]) begin
			fail_run(what);
		end
	endtask

	task automatic apply_reset();
		rst_i            = 1'b1;
		pay_valid_i      = 1'b0;
		pay_data_i       = '0;
		out_ready_i      = 1'b0;
		disperr_inject_i = 1'b0;
		slip_i           = 1'b0;
		xfer_q           = 1'b0;
		inj_total        = '0;
		byte_q.delete();
		repeat (RESET_CYCLES) begin
			@(posedge tx_clk);
			#2;
		end
		rst_i = 1'b0;
	endtask

	// Cycle k is the k-th rising edge after reset release
	task automatic check_power_up(input string name);
		mode = MODE_NONE;
		for (int k = 1; k <= UP_CYCLES + 2; k++) begin
			tick(1'b0, 1'b1, 1'b0, 1'b0);
			check_flag({name, " plllkdet"}, k >= PLL_LOCK_CYCLES, plllkdet_o);
			check_flag({name, " resetdone"}, k >= UP_CYCLES, resetdone_o);
			if (k <= UP_CYCLES) begin
				check_flag({name, " pay_ready"}, 1'b0, pay_ready_o);
				check_flag({name, " out_valid"}, 1'b0, out_valid_o);
				check_flag({name, " byte_aligned"}, 1'b0, rxstatus_o[3]);
				check_flag({name, " loss_of_sync"}, 1'b0, rxstatus_o[4]);
				check_status({name, " bufstatus"}, BUF_NOMINAL, buf_status_t'(rxstatus_o[2:0]));
				check_count({name, " disperr_count"}, '0, disperr_count_o);
			end
		end
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	initial begin
		int n;
		void'($urandom(84296));
		apply_reset();
		check_power_up("power_up");

		// Free-running sink
		cur_test = "bursts";
		mode     = MODE_EXACT;
		run_traffic(TRAFFIC, 0, 0);
		drain_exact();

		// Short sink stalls
		cur_test = "stalls";
		run_traffic(TRAFFIC, BUF_DEPTH - 3, 0);
		drain_exact();

		// Disparity errors, count must match the pulses
		cur_test = "disperr";
		run_traffic(TRAFFIC, 0, 8);
		drain_exact();
		// Idle words behind the last byte may still carry an error
		repeat (FLUSH) begin
			tick(1'b0, 1'b1, 1'b0, 1'b0);
		end
		check_count("disperr count", inj_total, disperr_count_o);

		// One slipped word, then realign
		cur_test = "slip";
		mode     = MODE_SUBSEQ;
		run_traffic(TRAFFIC / 2, 0, 0);
		tick(1'b1, 1'b1, 1'b0, 1'b1);
		wait_status_bit(3'd4, "slip: loss of sync never flagged after the slip");
		check_flag("slip byte_aligned dropped", 1'b0, rxstatus_o[3]);
		wait_status_bit(3'd3, "slip: deframer did not realign on a later comma");
		run_traffic(TRAFFIC / 2, 0, 0);
		check_flag("slip loss_of_sync held", 1'b1, rxstatus_o[4]);
		n = 0;
		while (byte_q.size() != 0 && n < DRAIN) begin
			tick(1'b0, 1'b1, 1'b0, 1'b0);
			n++;
		end
		byte_q.delete();

		// Long sink stall overflows the buffer
		cur_test = "overflow";
		mode     = MODE_NONE;
		for (int c = 0; c < OVF_CYCLES; c++) begin
			tick(1'b1, 1'b0, 1'b0, 1'b0);
		end
		check_status("overflow set", BUF_OVERFLOW, buf_status_t'(rxstatus_o[2:0]));
		for (int c = 0; c < 2 * BUF_DEPTH; c++) begin
			tick(1'b1, 1'b1, 1'b0, 1'b0);
		end
		check_status("overflow sticky", BUF_OVERFLOW, buf_status_t'(rxstatus_o[2:0]));
		check_flag("overflow loss_of_sync held", 1'b1, rxstatus_o[4]);

		// Reset clears every sticky flag
		apply_reset();
		check_power_up("overflow_reset");

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== all.f ====
link_pkg.sv
link_tx_framer.sv
lane_loopback.sv
rx_elastic_buffer.sv
rx_deframer.sv
link_top.sv
link_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= link_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
